// ==== rtl/beat_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_packer
    import dma_pkg::*;
#(
    parameter int N_CHANNELS      = 4,
    parameter int CHANNEL_SAMPLES = 16
) (
    input  wire                   clock,
    input  wire                   reset,
    input  wire channel_t         channel_select,
    input  wire                   frame_start,
    input  wire [N_CHANNELS-1:0]  buffer_valid,
    input  wire sample_t          buffer_data [N_CHANNELS],
    output logic [N_CHANNELS-1:0] pop,
    output logic                  beat_valid,
    output beat_t                 beat_data,
    input  wire                   beat_ready
);

    logic     sel_valid;
    sample_t  sel_data;
    channel_t prev_channel;
    index_t   index;
    index_t   cur_index;
    logic     take;
    word_t    word;
    word_t    low_word;
    logic     have_low;

    //////////////////////////////
    // Channel select and tagging
    //////////////////////////////

    always_comb begin
        sel_valid = 1'b0;
        sel_data  = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (channel_select == channel_t'(i)) begin
                sel_valid = buffer_valid[i];
                sel_data  = buffer_data[i];
            end
        end
    end

    // A new channel starts counting from zero in the same cycle
    assign cur_index = (channel_select != prev_channel) ? '0 : index;

    // The index parks at CHANNEL_SAMPLES once a channel is drained
    assign take = sel_valid && !frame_start
                  && (cur_index < index_t'(CHANNEL_SAMPLES))
                  && (!beat_valid || beat_ready);

    assign word = {cur_index, 8'h00, channel_select, sel_data};

    always_comb begin
        for (int i = 0; i < N_CHANNELS; i++) begin
            pop[i] = take && (channel_select == channel_t'(i));
        end
    end

    //////////////////////////////
    // Word pairing
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            prev_channel <= '0;
            index        <= index_t'(CHANNEL_SAMPLES);
            have_low     <= 1'b0;
            beat_valid   <= 1'b0;
        end else begin
            prev_channel <= channel_select;
            if (frame_start) begin
                index    <= '0;
                have_low <= 1'b0;
            end else if (take) begin
                index    <= cur_index + 1'b1;
                have_low <= !have_low;
            end else begin
                index <= cur_index;
            end
            if (take && have_low) begin
                beat_valid <= 1'b1;
            end else if (beat_ready) begin
                beat_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            if (have_low) begin
                beat_data <= {word, low_word};
            end else begin
                low_word <= word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/burst_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_writer
    import dma_pkg::*;
#(
    parameter int N_CHANNELS      = 4,
    parameter int CHANNEL_SAMPLES = 16,
    parameter int BURST_BEATS     = 4
) (
    input  wire             clock,
    input  wire             reset,
    input  wire             frame_ready,
    input  wire addr_t      base_addr,
    output channel_t        channel_select,
    output logic            frame_start,
    input  wire             beat_valid,
    input  wire beat_t      beat_data,
    output logic            beat_ready,
    output logic            awvalid,
    input  wire             awready,
    output addr_t           awaddr,
    output burst_len_t      awlen,
    output logic            wvalid,
    input  wire             wready,
    output beat_t           wdata,
    output logic            wlast,
    input  wire             bvalid,
    output logic            bready,
    output logic            dma_done
);

    localparam int BEAT_BYTES     = 16;
    localparam int BURST_BYTES    = BURST_BEATS * BEAT_BYTES;
    localparam int CHANNEL_BURSTS = CHANNEL_SAMPLES / (2 * BURST_BEATS);
    localparam int FRAME_BURSTS   = N_CHANNELS * CHANNEL_BURSTS;
    localparam int BURST_W        = $clog2(FRAME_BURSTS + 1);
    localparam int CHAN_BURST_W   = $clog2(CHANNEL_BURSTS + 1);
    localparam int BEAT_W         = $clog2(BURST_BEATS + 1);

    writer_state_t           state;
    addr_t                   frame_base;
    logic [BURST_W-1:0]      burst_count;
    logic [CHAN_BURST_W-1:0] channel_bursts;
    logic [BEAT_W-1:0]       beat_count;
    logic                    w_fire;

    //////////////////////////////
    // AXI channel outputs
    //////////////////////////////

    // Bursts are laid out back to back across all channels of the frame
    assign awaddr  = frame_base + addr_t'(burst_count) * addr_t'(BURST_BYTES);
    assign awlen   = burst_len_t'(BURST_BEATS - 1);
    assign awvalid = (state == st_address);

    // The packer holds its beat under back-pressure, so W payload stays stable
    assign wvalid     = (state == st_data) && beat_valid;
    assign wdata      = beat_data;
    assign wlast      = wvalid && (beat_count == BEAT_W'(BURST_BEATS - 1));
    assign beat_ready = (state == st_data) && wready;
    assign w_fire     = wvalid && wready;

    // Responses only arrive after wlast and are picked up in st_response
    assign bready = 1'b1;

    always_ff @(posedge clock) begin
        if (state == st_idle && frame_ready) begin
            frame_base <= base_addr;
        end
    end

    //////////////////////////////
    // Writer FSM
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state          <= st_idle;
            burst_count    <= '0;
            channel_bursts <= '0;
            beat_count     <= '0;
            channel_select <= '0;
            frame_start    <= 1'b0;
            dma_done       <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            dma_done    <= 1'b0;
            case (state)
                st_idle: begin
                    if (frame_ready) begin
                        burst_count    <= '0;
                        channel_bursts <= '0;
                        channel_select <= '0;
                        frame_start    <= 1'b1;
                        state          <= st_address;
                    end
                end
                st_address: begin
                    if (awready) begin
                        beat_count <= '0;
                        state      <= st_data;
                    end
                end
                st_data: begin
                    if (w_fire) begin
                        beat_count <= beat_count + 1'b1;
                        if (wlast) begin
                            state <= st_response;
                        end
                    end
                end
                st_response: begin
                    if (bvalid) begin
                        burst_count <= burst_count + 1'b1;
                        if (channel_bursts == CHAN_BURST_W'(CHANNEL_BURSTS - 1)) begin
                            state <= st_next_channel;
                        end else begin
                            channel_bursts <= channel_bursts + 1'b1;
                            state          <= st_address;
                        end
                    end
                end
                st_next_channel: begin
                    channel_bursts <= '0;
                    // The last channel stays selected so the packer remains parked
                    if (channel_select == channel_t'(N_CHANNELS - 1)) begin
                        dma_done <= 1'b1;
                        state    <= st_idle;
                    end else begin
                        channel_select <= channel_select + 1'b1;
                        state          <= st_address;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    aw_stable: assert property (@(posedge clock) disable iff (!reset)
        awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

`default_nettype wire

// ==== rtl/channel_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_buffer
    import dma_pkg::*;
#(
    parameter int CHANNEL_SAMPLES = 16
) (
    input  wire          clock,
    input  wire          reset,
    input  wire          push,
    input  wire sample_t push_data,
    input  wire          pop,
    output logic         buffer_valid,
    output sample_t      buffer_data
);

    localparam int PTR_W   = (CHANNEL_SAMPLES > 1) ? $clog2(CHANNEL_SAMPLES) : 1;
    localparam int COUNT_W = $clog2(CHANNEL_SAMPLES + 1);

    sample_t            mem [CHANNEL_SAMPLES];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;

    // Pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(CHANNEL_SAMPLES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // First word falls through, the head is always on the output
    assign buffer_valid = (count != '0);
    assign buffer_data  = mem[rd_ptr];

    // The router must respect its own fill count
    no_push_when_full: assert property (@(posedge clock) disable iff (!reset)
        push |-> (count != COUNT_W'(CHANNEL_SAMPLES)));

    // The packer must only pop a valid head
    no_pop_when_empty: assert property (@(posedge clock) disable iff (!reset)
        pop |-> (count != '0));

endmodule

`default_nettype wire

// ==== rtl/dma_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_capture_top
    import dma_pkg::*;
#(
    parameter int N_CHANNELS      = 4,
    parameter int CHANNEL_SAMPLES = 16,
    parameter int BURST_BEATS     = 4
) (
    input  wire             clock,
    input  wire             reset,
    input  wire             sample_valid,
    input  wire channel_t   sample_channel,
    input  wire sample_t    sample_data,
    output logic            sample_ready,
    input  wire addr_t      base_addr,
    output logic            awvalid,
    input  wire             awready,
    output addr_t           awaddr,
    output burst_len_t      awlen,
    output logic            wvalid,
    input  wire             wready,
    output beat_t           wdata,
    output logic            wlast,
    input  wire             bvalid,
    output logic            bready,
    output logic            dma_done
);

    logic [N_CHANNELS-1:0] push;
    sample_t               push_data;
    logic [N_CHANNELS-1:0] buffer_valid;
    sample_t               buffer_data [N_CHANNELS];
    logic [N_CHANNELS-1:0] pop;
    logic                  frame_ready;
    channel_t              channel_select;
    logic                  frame_start;
    logic                  beat_valid;
    beat_t                 beat_data;
    logic                  beat_ready;

    //////////////////////////////
    // Input side
    //////////////////////////////

    sample_router #(
        .N_CHANNELS      (N_CHANNELS),
        .CHANNEL_SAMPLES (CHANNEL_SAMPLES)
    ) u_router (
        .clock          (clock),
        .reset          (reset),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_data    (sample_data),
        .sample_ready   (sample_ready),
        .push           (push),
        .push_data      (push_data),
        .dma_done       (dma_done),
        .frame_ready    (frame_ready)
    );

    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_buffer
        channel_buffer #(
            .CHANNEL_SAMPLES (CHANNEL_SAMPLES)
        ) u_buffer (
            .clock        (clock),
            .reset        (reset),
            .push         (push[i]),
            .push_data    (push_data),
            .pop          (pop[i]),
            .buffer_valid (buffer_valid[i]),
            .buffer_data  (buffer_data[i])
        );
    end

    //////////////////////////////
    // Output side
    //////////////////////////////

    beat_packer #(
        .N_CHANNELS      (N_CHANNELS),
        .CHANNEL_SAMPLES (CHANNEL_SAMPLES)
    ) u_packer (
        .clock          (clock),
        .reset          (reset),
        .channel_select (channel_select),
        .frame_start    (frame_start),
        .buffer_valid   (buffer_valid),
        .buffer_data    (buffer_data),
        .pop            (pop),
        .beat_valid     (beat_valid),
        .beat_data      (beat_data),
        .beat_ready     (beat_ready)
    );

    burst_writer #(
        .N_CHANNELS      (N_CHANNELS),
        .CHANNEL_SAMPLES (CHANNEL_SAMPLES),
        .BURST_BEATS     (BURST_BEATS)
    ) u_writer (
        .clock          (clock),
        .reset          (reset),
        .frame_ready    (frame_ready),
        .base_addr      (base_addr),
        .channel_select (channel_select),
        .frame_start    (frame_start),
        .beat_valid     (beat_valid),
        .beat_data      (beat_data),
        .beat_ready     (beat_ready),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .awlen          (awlen),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wlast          (wlast),
        .bvalid         (bvalid),
        .bready         (bready),
        .dma_done       (dma_done)
    );

endmodule

`default_nettype wire

// ==== rtl/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    // One raw sample from the input stream
    typedef logic [31:0] sample_t;

    // Channel number, carried with every input sample
    typedef logic [7:0] channel_t;

    // Position of a sample inside its channel's frame
    typedef logic [15:0] index_t;

    // Packed output word
    // Index in bits 63:48, channel zero-extended in 47:32, sample in 31:0
    typedef logic [63:0] word_t;

    // One AXI data beat holding two words, the earlier one in the lower half
    typedef logic [127:0] beat_t;

    // AXI byte address
    typedef logic [31:0] addr_t;

    // AXI AWLEN field, beats per burst minus one
    typedef logic [7:0] burst_len_t;

    // Burst writer FSM states
    typedef enum logic [2:0] {
        st_idle,
        st_address,
        st_data,
        st_response,
        st_next_channel
    } writer_state_t;

endpackage

`default_nettype wire

// ==== rtl/sample_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_router
    import dma_pkg::*;
#(
    parameter int N_CHANNELS      = 4,
    parameter int CHANNEL_SAMPLES = 16
) (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   sample_valid,
    input  wire channel_t         sample_channel,
    input  wire sample_t          sample_data,
    output logic                  sample_ready,
    output logic [N_CHANNELS-1:0] push,
    output sample_t               push_data,
    input  wire                   dma_done,
    output logic                  frame_ready
);

    localparam int FILL_W = $clog2(CHANNEL_SAMPLES + 1);

    logic [FILL_W-1:0]     fill [N_CHANNELS];
    logic [N_CHANNELS-1:0] full;
    logic                  addressed_full;
    logic                  draining;

    // An out-of-range channel number looks full, so it is held off
    always_comb begin
        addressed_full = 1'b1;
        for (int i = 0; i < N_CHANNELS; i++) begin
            full[i] = (fill[i] == FILL_W'(CHANNEL_SAMPLES));
            if (sample_channel == channel_t'(i)) begin
                addressed_full = full[i];
            end
        end
    end

    assign sample_ready = sample_valid && !addressed_full;

    always_comb begin
        for (int i = 0; i < N_CHANNELS; i++) begin
            push[i] = sample_ready && (sample_channel == channel_t'(i));
        end
    end

    assign push_data = sample_data;

    // Goes high for the cycle the writer needs to see, then waits for dma_done
    assign frame_ready = (&full) && !draining;

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                fill[i] <= '0;
            end
            draining <= 1'b0;
        end else if (dma_done) begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                fill[i] <= '0;
            end
            draining <= 1'b0;
        end else begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                if (push[i]) begin
                    fill[i] <= fill[i] + 1'b1;
                end
            end
            if (frame_ready) begin
                draining <= 1'b1;
            end
        end
    end

    push_onehot: assert property (@(posedge clock) disable iff (!reset)
        $onehot0(push));

    // The writer only finishes a frame that this router has handed over
    done_while_draining: assert property (@(posedge clock) disable iff (!reset)
        dma_done |-> draining);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module tb_dma_capture -o sim_dma_capture
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_dma_capture 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== tb.f ====
rtl/dma_pkg.sv
rtl/sample_router.sv
rtl/channel_buffer.sv
rtl/beat_packer.sv
rtl/burst_writer.sv
rtl/dma_capture_top.sv
testbench/tb_memory_model.sv
testbench/tb_dma_capture.sv

// ==== testbench/tb_dma_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dma_capture
    import dma_pkg::*;
;

    localparam int          N_CHANNELS      = 4;
    localparam int          CHANNEL_SAMPLES = 16;
    localparam int          BURST_BEATS     = 4;
    localparam int          N_FRAMES        = 3;
    localparam int          CHANNEL_BURSTS  = CHANNEL_SAMPLES / (2 * BURST_BEATS);
    localparam int          FRAME_BURSTS    = N_CHANNELS * CHANNEL_BURSTS;
    localparam int          SEND_TIMEOUT    = 4000;
    localparam int          DONE_TIMEOUT    = 2000;
    localparam logic [31:0] RANDOM_SEED     = 32'h054f_2e9f;

    logic       clock = 1'b0;
    logic       reset;
    logic       sample_valid;
    channel_t   sample_channel;
    sample_t    sample_data;
    logic       sample_ready;
    addr_t      base_addr;
    logic       awvalid;
    logic       awready;
    addr_t      awaddr;
    burst_len_t awlen;
    logic       wvalid;
    logic       wready;
    beat_t      wdata;
    logic       wlast;
    logic       bvalid;
    logic       bready;
    logic       dma_done;
    logic       throttle;
    logic       format_error;

    logic [31:0] seed;
    sample_t     sent [N_FRAMES][N_CHANNELS][CHANNEL_SAMPLES];
    addr_t       bases [N_FRAMES];
    addr_t       aw_log [$];
    int          done_count;

    always #10 clock = ~clock;

    dma_capture_top #(
        .N_CHANNELS      (N_CHANNELS),
        .CHANNEL_SAMPLES (CHANNEL_SAMPLES),
        .BURST_BEATS     (BURST_BEATS)
    ) uut (
        .clock          (clock),
        .reset          (reset),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_data    (sample_data),
        .sample_ready   (sample_ready),
        .base_addr      (base_addr),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .awlen          (awlen),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wlast          (wlast),
        .bvalid         (bvalid),
        .bready         (bready),
        .dma_done       (dma_done)
    );

    tb_memory_model #(
        .BURST_BEATS (BURST_BEATS),
        .SEED        (RANDOM_SEED)
    ) memory (
        .clock        (clock),
        .reset        (reset),
        .throttle     (throttle),
        .base_addr    (base_addr),
        .dma_done     (dma_done),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .awlen        (awlen),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wlast        (wlast),
        .bvalid       (bvalid),
        .bready       (bready),
        .format_error (format_error)
    );

    //////////////////////////////
    // Reference and checks
    //////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] current);
        return current * 32'd1664525 + 32'd1013904223;
    endfunction

    // Index on top, channel zero-extended to 16 bits, sample at the bottom
    function automatic word_t expected_word(input int frame, input int channel, input int index);
        return {index_t'(index), 16'(channel), sent[frame][channel][index]};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, expected));
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, expected));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t expected);
        if (got !== expected) begin
            abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, expected));
        end
    endtask

    // Logs every accepted burst address and counts done pulses
    always @(posedge clock) begin
        if (reset && awvalid && awready) begin
            aw_log.push_back(awaddr);
        end
        if (reset && dma_done) begin
            done_count++;
        end
    end

    always @(posedge clock) begin
        if (format_error) begin
            abort_run("The memory model saw a malformed AXI write burst");
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic check_idle();
        repeat (4) begin
            @(posedge clock);
            check_bit("awvalid", awvalid, 1'b0);
            check_bit("wvalid", wvalid, 1'b0);
            check_bit("dma_done", dma_done, 1'b0);
            check_bit("bready", bready, 1'b1);
            check_bit("sample_ready", sample_ready, 1'b0);
        end
        #1;
    endtask

    // Ordered mode fills channel 0 first, random mode also tries channel N_CHANNELS
    task automatic send_frame(input int frame, input bit ordered);
        int   fill [N_CHANNELS];
        int   accepted;
        int   cycles;
        int   ch;
        logic ready_expected;
        for (int i = 0; i < N_CHANNELS; i++) begin
            fill[i] = 0;
        end
        accepted = 0;
        cycles   = 0;
        while (accepted < N_CHANNELS * CHANNEL_SAMPLES) begin
            if (cycles == SEND_TIMEOUT) begin
                abort_run($sformatf("Frame %0d was not accepted in time", frame));
            end
            cycles++;
            seed = next_random(seed);
            if (ordered) begin
                ch = accepted / CHANNEL_SAMPLES;
            end else begin
                ch = int'(seed[23:16]) % (N_CHANNELS + 1);
            end
            seed           = next_random(seed);
            sample_valid   = 1'b1;
            sample_channel = channel_t'(ch);
            sample_data    = seed;
            @(posedge clock);
            ready_expected = 1'b0;
            if (ch < N_CHANNELS) begin
                ready_expected = (fill[ch] < CHANNEL_SAMPLES);
            end
            check_bit("sample_ready", sample_ready, ready_expected);
            if (sample_ready) begin
                sent[frame][ch][fill[ch]] = sample_data;
                fill[ch]++;
                accepted++;
            end
            #1;
        end
        sample_valid = 1'b0;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                abort_run("The DMA never signalled the end of the frame");
            end
        end while (!dma_done);
        #1;
    endtask

    task automatic compare_frame(input int frame);
        addr_t addr;
        int    ch;
        int    first;
        if (done_count != frame + 1) begin
            abort_run($sformatf("Saw %0d done pulses after %0d frames", done_count, frame + 1));
        end
        if (aw_log.size() != (frame + 1) * FRAME_BURSTS) begin
            abort_run($sformatf("Frame %0d issued the wrong number of bursts", frame));
        end
        for (int k = 0; k < FRAME_BURSTS; k++) begin
            ch    = k / CHANNEL_BURSTS;
            first = (k % CHANNEL_BURSTS) * 2 * BURST_BEATS;
            addr  = bases[frame] + addr_t'((ch * CHANNEL_SAMPLES + first) * 8);
            check_addr("awaddr", aw_log[frame * FRAME_BURSTS + k], addr);
        end
        for (int c = 0; c < N_CHANNELS; c++) begin
            for (int i = 0; i < CHANNEL_SAMPLES; i++) begin
                addr = bases[frame] + addr_t'((c * CHANNEL_SAMPLES + i) * 8);
                if (!memory.mem.exists(addr)) begin
                    abort_run($sformatf("Nothing was written at address %h", addr));
                end
                check_word($sformatf("mem[%h]", addr), memory.mem[addr],
                           expected_word(frame, c, i));
            end
        end
    endtask

    initial begin
        reset          = 1'b0;
        sample_valid   = 1'b0;
        sample_channel = '0;
        sample_data    = '0;
        base_addr      = '0;
        throttle       = 1'b0;
        seed           = RANDOM_SEED;
        bases[0]       = 32'h1000_0000;
        bases[1]       = 32'h2000_4000;
        bases[2]       = 32'h3008_0200;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b1;
        check_idle();

        // First frame in channel order with a free bus, later ones interleaved and throttled
        for (int f = 0; f < N_FRAMES; f++) begin
            base_addr = bases[f];
            throttle  = (f != 0);
            send_frame(f, f == 0);
            wait_for_done();
            compare_frame(f);
        end

        repeat (5) @(posedge clock);
        #1;
        if (format_error || done_count != N_FRAMES) begin
            abort_run("Extra activity followed the last frame");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_memory_model
    import dma_pkg::*;
#(
    parameter int          BURST_BEATS = 4,
    parameter logic [31:0] SEED        = 32'h054f_2e9f
) (
    input  wire             clock,
    input  wire             reset,
    input  wire             throttle,
    input  wire addr_t      base_addr,
    input  wire             dma_done,
    input  wire             awvalid,
    output logic            awready,
    input  wire addr_t      awaddr,
    input  wire burst_len_t awlen,
    input  wire             wvalid,
    output logic            wready,
    input  wire beat_t      wdata,
    input  wire             wlast,
    output logic            bvalid,
    input  wire             bready,
    output logic            format_error
);

    // Every written 64-bit word, keyed by its byte address
    word_t mem [addr_t];

    addr_t       burst_addr [$];
    int          burst_count;
    int          beat_count;
    int          pending_b;
    logic [31:0] state;

    function automatic logic [31:0] next_random(input logic [31:0] current);
        return current * 32'd1664525 + 32'd1013904223;
    endfunction

    //////////////////////////////
    // AW channel
    //////////////////////////////

    task automatic accept_address();
        addr_t expected;
        if (awvalid && awready) begin
            // Bursts of one frame sit back to back from the base address
            expected = base_addr + addr_t'(burst_count * BURST_BEATS * 16);
            if (awlen !== burst_len_t'(BURST_BEATS - 1)) begin
                $display("[FAIL] awlen: got %h, expected %h", awlen,
                         burst_len_t'(BURST_BEATS - 1));
                format_error = 1'b1;
            end
            if (awaddr !== expected) begin
                $display("[FAIL] awaddr: got %h, expected %h", awaddr, expected);
                format_error = 1'b1;
            end
            burst_addr.push_back(awaddr);
            burst_count++;
        end
    endtask

    //////////////////////////////
    // W channel
    //////////////////////////////

    task automatic accept_data();
        addr_t addr;
        logic  last_expected;
        if (wvalid && wready) begin
            if (burst_addr.size() == 0) begin
                $display("Write data arrived before any burst address was accepted");
                format_error = 1'b1;
            end else begin
                addr = burst_addr[0] + addr_t'(beat_count * 16);
                // The earlier word of a beat is in the lower half
                mem[addr] = wdata[63:0];
                mem[addr + addr_t'(8)] = wdata[127:64];
                last_expected = (beat_count == BURST_BEATS - 1);
                if (wlast !== last_expected) begin
                    $display("[FAIL] wlast: got %h, expected %h", wlast, last_expected);
                    format_error = 1'b1;
                end
                if (last_expected) begin
                    void'(burst_addr.pop_front());
                    beat_count = 0;
                    pending_b++;
                end else begin
                    beat_count++;
                end
            end
        end
    endtask

    initial begin
        awready      = 1'b0;
        wready       = 1'b0;
        bvalid       = 1'b0;
        format_error = 1'b0;
        burst_count  = 0;
        beat_count   = 0;
        pending_b    = 0;
        state        = SEED;
        forever begin
            @(posedge clock);
            if (reset) begin
                accept_address();
                accept_data();
                if (bvalid && bready) begin
                    pending_b--;
                end
                if (dma_done) begin
                    burst_count = 0;
                end
            end
            #1;
            state   = next_random(state);
            awready = reset && (!throttle || state[31:30] != 2'b00);
            wready  = reset && (!throttle || state[29:28] != 2'b00);
            // A raised response holds until it is taken
            if (!(bvalid && !bready)) begin
                bvalid = reset && (pending_b > 0) && (!throttle || state[27]);
            end
        end
    end

endmodule

`default_nettype wire
